// File: include/opl3_host_defs.svh
/*
 * opl3 host interface constants
 * bus data width, register bank depth and timer tick prescale counts
 */
`ifndef OPL3_HOST_DEFS_SVH
`define OPL3_HOST_DEFS_SVH

// host data bus and register width
`define OPL3_DATA_WIDTH 8

// registers per bank, two banks in total
`define OPL3_REG_COUNT 256

// clk_host cycles per timer 1 tick
`define OPL3_T1_PRESCALE 4

// clk_host cycles per timer 2 tick, four times timer 1 like the real chip
`define OPL3_T2_PRESCALE 16

`endif

// File: src/opl3_host_pkg.sv
/*
 * opl3 host package
 * shared vector types and the bus sequencer state encoding
 */
`default_nettype none

`include "opl3_host_defs.svh"

package opl3_host_pkg;

    // one register or bus byte
    typedef logic [`OPL3_DATA_WIDTH-1:0] reg_data_t;

    // register index within a bank
    typedef logic [$clog2(`OPL3_REG_COUNT)-1:0] reg_index_t;

    // a0 selects index or data phase, a1 selects the bank on index writes
    typedef logic [1:0] bus_addr_t;

    // timer count and preset, same width as a register
    typedef logic [`OPL3_DATA_WIDTH-1:0] timer_count_t;

    // bus sequencer states
    typedef enum logic [1:0] {
        bus_idle,           // waiting for a strobe
        bus_strobe_hold,    // write taken, wait for release
        bus_read_hold       // read taken, wait for release
    } bus_state_t;

endpackage

`default_nettype wire

// File: src/opl3_host_ifs.sv
/*
 * internal opl3 host interfaces
 * register write channel from the bus sequencer, timer control bundle
 */
`timescale 1ns/1ns
`default_nettype none

interface reg_write_if;
    import opl3_host_pkg::*;

    logic       valid;  // one pulse per data write
    logic       bank;   // 0 = primary, 1 = secondary
    reg_index_t index;
    reg_data_t  data;

    modport source (output valid, bank, index, data);
    modport sink   (input valid, bank, index, data);
endinterface

interface timer_ctrl_if;
    import opl3_host_pkg::*;

    timer_count_t t1_preset;    // reg 0x02
    timer_count_t t2_preset;    // reg 0x03
    logic         start1;       // reg 0x04 bit 0
    logic         start2;       // reg 0x04 bit 1
    logic         mask1;        // reg 0x04 bit 6
    logic         mask2;        // reg 0x04 bit 5
    logic         rst_irq;      // one cycle pulse, clears flags

    modport ctrl  (output t1_preset, t2_preset, start1, start2, mask1, mask2, rst_irq);
    modport timer (input t1_preset, t2_preset, start1, start2, mask1, mask2, rst_irq);
endinterface

`default_nettype wire

// File: src/host_bus_fsm.sv
/*
 * host bus sequencer
 * turns cs/rd/wr strobes into index latches, data write pulses and status reads,
 * acting once per strobe however long it is held
 */
`timescale 1ns/1ns
`default_nettype none

module host_bus_fsm (
    input  logic                     clk_host,
    input  logic                     reset,
    input  logic                     cs_n,
    input  logic                     rd_n,
    input  logic                     wr_n,
    input  opl3_host_pkg::bus_addr_t address,
    input  opl3_host_pkg::reg_data_t din,
    output opl3_host_pkg::reg_data_t dout,
    input  opl3_host_pkg::reg_data_t status,
    reg_write_if.source              wr
);
    import opl3_host_pkg::*;

    bus_state_t state;
    reg_index_t index_q;    // latched by index phase
    logic       bank_q;     // latched from a1 with the index
    logic       wr_strobe;
    logic       rd_strobe;
    logic       data_phase;

    // exactly one strobe with chip select
    assign wr_strobe  = !cs_n && !wr_n && rd_n;
    assign rd_strobe  = !cs_n && !rd_n && wr_n;
    assign data_phase = wr_strobe && address[0];    // a0 set = data write

    assign wr.index = index_q;  // held steady between index writes
    assign wr.bank  = bank_q;

    always_ff @(posedge clk_host) begin
        if (reset) begin
            state    <= bus_idle;
            index_q  <= '0;         // data before index lands at bank 0 reg 0
            bank_q   <= 1'b0;
            wr.valid <= 1'b0;
            dout     <= '0;
        end else begin
            wr.valid <= 1'b0;       // pulse default
            case (state)
                bus_idle: begin
                    if (wr_strobe) begin
                        if (address[0]) begin
                            wr.valid <= 1'b1;   // data phase
                        end else begin
                            index_q <= din;         // index phase
                            bank_q  <= address[1];  // a1 picks the bank
                        end
                        state <= bus_strobe_hold;
                    end else if (rd_strobe) begin
                        dout  <= status;    // any address reads status
                        state <= bus_read_hold;
                    end
                end
                bus_strobe_hold: begin
                    if (cs_n || wr_n) begin
                        state <= bus_idle;  // strobe released
                    end
                end
                bus_read_hold: begin
                    if (cs_n || rd_n) begin
                        state <= bus_idle;
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // write byte, only meaningful alongside valid
    always_ff @(posedge clk_host) begin
        if (state == bus_idle && data_phase) begin
            wr.data <= din;
        end
    end

    // a long strobe must never produce back-to-back writes
    a_valid_single: assert property (@(posedge clk_host) disable iff (reset)
        wr.valid |=> !wr.valid);

    // every write pulse comes from a selected data-phase strobe the cycle before
    a_valid_from_cs: assert property (@(posedge clk_host) disable iff (reset)
        wr.valid |-> $past(!cs_n && !wr_n && address[0]));

endmodule

`default_nettype wire

// File: src/register_bank.sv
/*
 * two-bank opl3 register file
 * takes bus writes, serves a registered read port for the synthesis core
 * and decodes the bank 0 timer registers for the timer block
 */
`timescale 1ns/1ns
`default_nettype none

`include "opl3_host_defs.svh"

module register_bank (
    input  logic                      clk_host,
    input  logic                      reset,
    reg_write_if.sink                 wr,
    timer_ctrl_if.ctrl                tctl,
    input  logic                      core_bank,
    input  opl3_host_pkg::reg_index_t core_index,
    output opl3_host_pkg::reg_data_t  core_data
);
    import opl3_host_pkg::*;

    // bank 0 timer register map
    localparam reg_index_t t1_preset_idx = 8'h02;
    localparam reg_index_t t2_preset_idx = 8'h03;
    localparam reg_index_t timer_ctl_idx = 8'h04;

    reg_data_t regs [2][`OPL3_REG_COUNT];
    reg_data_t ctl;             // stored timer control byte
    logic      ctl_write;       // write hits bank 0 reg 0x04
    logic      flag_reset;      // control write with bit 7
    logic      rst_irq_q;

    assign ctl_write  = wr.valid && !wr.bank && (wr.index == timer_ctl_idx);
    assign flag_reset = ctl_write && wr.data[7];

    always_ff @(posedge clk_host) begin
        if (reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `OPL3_REG_COUNT; i++) begin
                    regs[b][i] <= '0;   // all registers clear after reset
                end
            end
            rst_irq_q <= 1'b0;
        end else begin
            rst_irq_q <= flag_reset;
            // bit 7 writes only pulse rst_irq, start/mask stay as they were
            if (wr.valid && !flag_reset) begin
                regs[wr.bank][wr.index] <= wr.data;
            end
        end
    end

    // core read port, one cycle latency
    always_ff @(posedge clk_host) begin
        core_data <= regs[core_bank][core_index];
    end

    assign ctl = regs[0][timer_ctl_idx];

    assign tctl.t1_preset = regs[0][t1_preset_idx];
    assign tctl.t2_preset = regs[0][t2_preset_idx];
    assign tctl.start1    = ctl[0];
    assign tctl.start2    = ctl[1];
    assign tctl.mask2     = ctl[5];
    assign tctl.mask1     = ctl[6];
    assign tctl.rst_irq   = rst_irq_q;

    // flag reset pulse only ever follows a bank 0 control write
    a_rst_irq_src: assert property (@(posedge clk_host) disable iff (reset)
        tctl.rst_irq |-> $past(wr.valid && !wr.bank && wr.index == 8'h04));

endmodule

`default_nettype wire

// File: src/opl3_timers.sv
/*
 * opl3 timer pair
 * prescaled 8-bit up counters with preset reload, sticky overflow flags,
 * status byte and active-low interrupt
 */
`timescale 1ns/1ns
`default_nettype none

`include "opl3_host_defs.svh"

module opl3_timers (
    input  logic                     clk_host,
    input  logic                     reset,
    timer_ctrl_if.timer              tctl,
    output opl3_host_pkg::reg_data_t status,
    output logic                     irq_n
);
    import opl3_host_pkg::*;

    // sized for the slower timer, one spare bit
    localparam int pre_w = $clog2(`OPL3_T2_PRESCALE) + 1;

    logic [1:0]   start_v;      // index 0 = timer 1
    logic [1:0]   mask_v;
    logic [1:0]   ovf;          // overflow pulse per timer
    logic [1:0]   flag;         // sticky flags
    timer_count_t preset_v [2];
    logic         any_flag;

    assign start_v     = {tctl.start2, tctl.start1};
    assign mask_v      = {tctl.mask2, tctl.mask1};
    assign preset_v[0] = tctl.t1_preset;
    assign preset_v[1] = tctl.t2_preset;

    for (genvar i = 0; i < 2; i++) begin : g_timer
        localparam int prescale = (i == 0) ? `OPL3_T1_PRESCALE : `OPL3_T2_PRESCALE;

        logic [pre_w-1:0] pre_cnt;  // clk_host cycles within a tick
        timer_count_t     count;
        logic             start_d;  // start delayed, for edge detect
        logic             tick;
        logic             flag_q;

        assign tick   = (pre_cnt == pre_w'(prescale - 1));
        // no overflow on the load cycle itself
        assign ovf[i] = start_v[i] && start_d && tick && (count == '1);

        always_ff @(posedge clk_host) begin
            if (reset) begin
                pre_cnt <= '0;
                count   <= '0;
                start_d <= 1'b0;
            end else begin
                start_d <= start_v[i];
                if (start_v[i] && !start_d) begin
                    pre_cnt <= '0;              // rising start, load preset
                    count   <= preset_v[i];
                end else if (start_v[i]) begin
                    pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
                    if (tick) begin
                        // past 0xff reload, so p overflows after 256 - p ticks
                        count <= (count == '1) ? preset_v[i] : count + 1'b1;
                    end
                end
                // stopped timer holds its count
            end
        end

        always_ff @(posedge clk_host) begin
            if (reset) begin
                flag_q <= 1'b0;
            end else if (tctl.rst_irq) begin
                flag_q <= 1'b0;             // reset wins over a same-cycle overflow
            end else if (ovf[i] && !mask_v[i]) begin
                flag_q <= 1'b1;             // masked overflow leaves flag alone
            end
        end

        assign flag[i] = flag_q;
    end

    assign any_flag = |flag;

    // bit 7 irq, bit 6 timer 1, bit 5 timer 2
    assign status = {any_flag, flag[0], flag[1], {(`OPL3_DATA_WIDTH-3){1'b0}}};

    // released together with the flags when rst_irq arrives
    always_ff @(posedge clk_host) begin
        if (reset) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !(any_flag && !tctl.rst_irq);
        end
    end

    // irq low once a flag has been up a full cycle, high again as soon as flags drop
    a_irq_tracks_flags: assert property (@(posedge clk_host) disable iff (reset)
        !irq_n == (any_flag && $past(any_flag)));

endmodule

`default_nettype wire

// File: src/opl3_host.sv
/*
 * opl3 host side top
 * cpu bus sequencer, register file and timers behind plain ports
 */
`timescale 1ns/1ns
`default_nettype none

module opl3_host (
    input  logic                      clk_host,
    input  logic                      reset,
    input  logic                      cs_n,
    input  logic                      rd_n,
    input  logic                      wr_n,
    input  opl3_host_pkg::bus_addr_t  address,
    input  opl3_host_pkg::reg_data_t  din,
    output opl3_host_pkg::reg_data_t  dout,
    output logic                      irq_n,
    input  logic                      core_bank,
    input  opl3_host_pkg::reg_index_t core_index,
    output opl3_host_pkg::reg_data_t  core_data
);
    import opl3_host_pkg::*;

    reg_data_t status;      // timers to bus read path

    reg_write_if  wr_bus ();    // sequencer -> register file
    timer_ctrl_if tctl_bus ();  // register file -> timers

    host_bus_fsm host_bus_fsm_inst (
        .clk_host (clk_host),
        .reset    (reset),
        .cs_n     (cs_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .address  (address),
        .din      (din),
        .dout     (dout),
        .status   (status),
        .wr       (wr_bus.source)
    );

    register_bank register_bank_inst (
        .clk_host   (clk_host),
        .reset      (reset),
        .wr         (wr_bus.sink),
        .tctl       (tctl_bus.ctrl),
        .core_bank  (core_bank),
        .core_index (core_index),
        .core_data  (core_data)
    );

    opl3_timers opl3_timers_inst (
        .clk_host (clk_host),
        .reset    (reset),
        .tctl     (tctl_bus.timer),
        .status   (status),
        .irq_n    (irq_n)
    );

endmodule

`default_nettype wire

// File: verification/opl3_host_tb.sv
/*
 * opl3 host testbench
 * bus and core port stimulus, timer detection sequence and register map checks
 */
`timescale 1ns/1ns
`default_nettype none

`include "opl3_host_defs.svh"

module opl3_host_tb;
    import opl3_host_pkg::*;

    localparam int t2_period   = 256 * `OPL3_T2_PRESCALE;  // full timer 2 run, preset 0
    // test 4 has two timer 2 runs, test 5 one, the rest fit in the margin
    localparam int cycle_limit = 3 * t2_period + 2000;

    logic        clk_host;
    logic        reset;
    logic        cs_n;
    logic        rd_n;
    logic        wr_n;
    bus_addr_t   address;
    reg_data_t   din;
    reg_data_t   dout;
    logic        irq_n;
    logic        core_bank;
    reg_index_t  core_index;
    reg_data_t   core_data;

    reg_data_t   model [2][256];    // expected register contents
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          test_err = 0;      // error count when the test began
    int          seed;
    logic [31:0] r;
    reg_data_t   rd_val;
    logic        wb [32];           // random write targets for test 6
    reg_index_t  wi [32];

    opl3_host opl3_host_inst (
        .clk_host   (clk_host),
        .reset      (reset),
        .cs_n       (cs_n),
        .rd_n       (rd_n),
        .wr_n       (wr_n),
        .address    (address),
        .din        (din),
        .dout       (dout),
        .irq_n      (irq_n),
        .core_bank  (core_bank),
        .core_index (core_index),
        .core_data  (core_data)
    );

    initial begin
        clk_host = 1'b0;
        forever #20 clk_host = ~clk_host;   // 40 ns period
    end

    always @(posedge clk_host) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // dout only moves on the edge that takes a read strobe
    a_dout_hold: assert property (@(posedge clk_host) disable iff (reset)
        !$past(!cs_n && !rd_n) |-> $stable(dout))
        else begin
            $display("dout changed at %0t without a read strobe", $time);
            errors++;
        end

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        assert (act == exp) else begin
            $display("[FAIL] %0t ns %s expected %02h actual %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_write_index(input logic bank, input reg_index_t index);
        @(negedge clk_host);
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = {bank, 1'b0};     // a0 clear, a1 picks bank
        din     = index;
        @(negedge clk_host);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic bus_write_data(input reg_data_t data);
        @(negedge clk_host);
        cs_n    = 1'b0;
        wr_n    = 1'b0;
        address = 2'b01;            // data phase
        din     = data;
        @(negedge clk_host);
        cs_n = 1'b1;
        wr_n = 1'b1;
        @(negedge clk_host);        // bank write lands on this edge
    endtask

    task automatic bus_read(output reg_data_t val);
        @(negedge clk_host);
        cs_n    = 1'b0;
        rd_n    = 1'b0;
        address = 2'b00;
        @(negedge clk_host);
        val  = dout;                // registered on the edge in between
        cs_n = 1'b1;
        rd_n = 1'b1;
    endtask

    task automatic core_read(input logic bank, input reg_index_t index, output reg_data_t val);
        @(negedge clk_host);
        core_bank  = bank;
        core_index = index;
        @(negedge clk_host);
        val = core_data;            // one cycle latency
    endtask

    task automatic reg_write(input logic bank, input reg_index_t index, input reg_data_t data);
        bus_write_index(bank, index);
        bus_write_data(data);
        // flag reset writes are not stored
        if (!(bank == 1'b0 && index == 8'h04 && data[7])) begin
            model[bank][index] = data;
        end
    endtask

    task automatic check_core(input logic bank, input reg_index_t index);
        reg_data_t val;
        core_read(bank, index, val);
        check_value($sformatf("core_data[%0d][%02h]", bank, index), model[bank][index], val);
    endtask

    task automatic wait_irq_low(input int bound);
        int n;
        n = 0;
        while (irq_n && n < bound) begin
            @(negedge clk_host);
            n++;
        end
        assert (!irq_n) else begin
            $display("irq_n did not go low within %0d cycles at %0t ns", bound, $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s", name, (errors == test_err) ? "ok" : "failed");
        test_err = errors;
    endtask

    initial begin
        cs_n       = 1'b1;
        rd_n       = 1'b1;
        wr_n       = 1'b1;
        address    = 2'b00;
        din        = 8'h00;
        core_bank  = 1'b0;
        core_index = 8'h00;
        reset      = 1'b1;
        seed       = 32'h4931;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 256; i++) begin
                model[b][i] = 8'h00;
            end
        end
        repeat (8) @(negedge clk_host);
        reset = 1'b0;

        check_value("irq_n", 8'h01, reg_data_t'(irq_n));
        bus_read(rd_val);
        check_value("dout", 8'h00, rd_val);
        check_core(1'b0, 8'h00);
        check_core(1'b0, 8'h04);
        check_core(1'b1, 8'h02);
        check_core(1'b1, 8'hFF);
        end_test("1 reset state");

        bus_write_data(8'h5A);          // no index yet, goes to bank 0 reg 0
        model[0][0] = 8'h5A;
        check_core(1'b0, 8'h00);
        reg_write(1'b0, 8'h40, 8'h3C);
        reg_write(1'b1, 8'h40, 8'hC3);
        reg_write(1'b1, 8'hB0, 8'h11);
        check_core(1'b0, 8'h40);
        check_core(1'b1, 8'h40);
        check_core(1'b1, 8'hB0);
        check_core(1'b0, 8'hB0);        // bank 0 copy untouched
        end_test("2 bank writes");

        reg_write(1'b0, 8'h04, 8'h60);  // mask both timers
        reg_write(1'b0, 8'h04, 8'h80);  // clear flags
        bus_read(rd_val);
        check_value("status & e0", 8'h00, rd_val & 8'hE0);
        reg_write(1'b0, 8'h02, 8'hFF);
        reg_write(1'b0, 8'h04, 8'h21);  // start timer 1, timer 2 masked
        repeat (64) @(negedge clk_host);
        bus_read(rd_val);
        check_value("status & e0", 8'hC0, rd_val & 8'hE0);
        check_value("irq_n", 8'h00, reg_data_t'(irq_n));
        end_test("3 detection sequence");

        reg_write(1'b0, 8'h04, 8'h60);  // stop both
        reg_write(1'b0, 8'h04, 8'h80);
        reg_write(1'b0, 8'h03, 8'h00);  // longest timer 2 period
        reg_write(1'b0, 8'h04, 8'h22);  // start timer 2 masked
        repeat (t2_period) @(negedge clk_host);
        bus_read(rd_val);
        check_value("status", 8'h00, rd_val);
        check_value("irq_n", 8'h01, reg_data_t'(irq_n));
        reg_write(1'b0, 8'h04, 8'h02);  // unmask, counter keeps running
        wait_irq_low(t2_period + 64);
        bus_read(rd_val);
        check_value("status", 8'hA0, rd_val);
        end_test("4 timer 2 mask");

        reg_write(1'b0, 8'h04, 8'h80);  // flag reset, timer 2 still started
        bus_read(rd_val);
        check_value("status", 8'h00, rd_val);
        check_value("irq_n", 8'h01, reg_data_t'(irq_n));
        wait_irq_low(t2_period + 64);
        bus_read(rd_val);
        check_value("status", 8'hA0, rd_val);
        end_test("5 flag reset");

        for (int k = 0; k < 32; k++) begin
            do begin
                r = $random(seed);
            end while (!r[8] && r[7:0] >= 8'h02 && r[7:0] <= 8'h04);   // skip timer regs
            wb[k] = r[8];
            wi[k] = r[7:0];
            reg_write(r[8], r[7:0], r[23:16]);
        end
        for (int k = 0; k < 32; k++) begin
            check_core(wb[k], wi[k]);
        end
        end_test("6 random writes");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
src/opl3_host_pkg.sv
src/opl3_host_ifs.sv
src/host_bus_fsm.sv
src/register_bank.sv
src/opl3_timers.sv
src/opl3_host.sv
verification/opl3_host_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the opl3 host testbench with verilator, verdict taken from sim.log
verilator --binary --timing --assert -f sim.f --top-module opl3_host_tb > sim.log 2>&1 &&
./obj_dir/Vopl3_host_tb >> sim.log 2>&1
grep -q "^Simulation finished: PASS$" sim.log && echo "run passed, see sim.log" ||
{ echo "run failed, see sim.log"; exit 1; }
